// ==== flist.f ====
+incdir+.
memPkg.sv
storeFormatter.sv
loadExtender.sv
memoryStage.sv
dataRam.sv
memSubsystem.sv
tbClock.sv
memSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -j 0 \
    --top-module memSubsystemTb \
    -f flist.f \
    --Mdir "$BUILD_DIR" -o simv > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build error, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/simv" > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"

if grep -q "Simulation failed" "$SIM_LOG"; then
    echo "Result: FAIL"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Result: FAIL (simulator exit status $simStatus)"
    exit 1
fi
echo "Result: PASS"
exit 0

// ==== memSubsystemTb.sv ====
`default_nettype none

`include "memConfig_config.svh"

module memSubsystemTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod     = 40;
    localparam int NumInstr      = 400;
    localparam int HotWords      = 16;
    localparam int ByteAw        = $clog2(`RAM_WORDS * 8);
    localparam int TimeoutCycles = (NumInstr + HotWords) * (`RAM_LATENCY + 3) + 100;

    logic            clk;
    logic            reset;
    logic            flush;
    memPkg::execData dataE;
    logic            memStall;
    memPkg::memData  dataM;

    logic [7:0]      refMem [0:`RAM_WORDS*8-1];
    int unsigned     seedValue;

    tbClock #(.Period(ClkPeriod)) tbClock_inst (.clk(clk));

    memSubsystem memSubsystem_inst (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .dataE    (dataE),
        .memStall (memStall),
        .dataM    (dataM)
    );

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopping at the first error.");
        end
    endtask

    function automatic int unsigned opBytes(input memPkg::memOp op);
        case (op)
            memPkg::opLd, memPkg::opSd:                 return 8;
            memPkg::opLw, memPkg::opLwu, memPkg::opSw:  return 4;
            memPkg::opLh, memPkg::opLhu, memPkg::opSh:  return 2;
            default:                                    return 1;
        endcase
    endfunction

    function automatic logic isStoreOp(input memPkg::memOp op);
        return op inside {memPkg::opSd, memPkg::opSw, memPkg::opSh, memPkg::opSb};
    endfunction

    function automatic logic isSignedLoad(input memPkg::memOp op);
        return op inside {memPkg::opLw, memPkg::opLh, memPkg::opLb};
    endfunction

    // Little-endian gather from the reference bytes, then extension.
    function automatic logic [63:0] expectLoad(input memPkg::memOp op, input logic [63:0] addr);
        int unsigned       nBytes;
        logic [63:0]       v;
        logic [ByteAw-1:0] base;
        nBytes = opBytes(op);
        base = addr[ByteAw-1:0];
        v = '0;
        for (int i = 0; i < nBytes; i++) begin
            v[8*i +: 8] = refMem[base + ByteAw'(i)];
        end
        if (isSignedLoad(op) && v[8*nBytes-1]) begin
            v = v | (~64'h0 << (8 * nBytes));
        end
        return v;
    endfunction

    function automatic void applyStore(input memPkg::execData ins);
        int unsigned       nBytes;
        logic [ByteAw-1:0] base;
        nBytes = opBytes(ins.ctl.op);
        base = ins.aluOut[ByteAw-1:0];
        for (int i = 0; i < nBytes; i++) begin
            refMem[base + ByteAw'(i)] = ins.rd[8*i +: 8];
        end
    endfunction

    function automatic logic pickFlush();
        return ($urandom % 8) == 0;
    endfunction

    function automatic memPkg::execData makeInstr();
        memPkg::execData ins;
        memPkg::memOp    op;
        int unsigned     nBytes;
        int unsigned     wordIdx;
        int unsigned     offset;
        ins = '0;
        if ($urandom % 100 < 60) begin
            op = memPkg::memOp'(4'(1 + $urandom % 11));
        end else begin
            op = memPkg::opNone;
        end
        ins.valid = ($urandom % 20) != 0;
        ins.ctl.op = op;
        ins.ctl.memAccess = (op != memPkg::opNone);
        ins.rd = {$urandom, $urandom};
        ins.dst = 5'($urandom);
        ins.instr = $urandom;
        if (ins.ctl.memAccess) begin
            nBytes = opBytes(op);
            // Most accesses land in a few words so stores and loads overlap.
            if ($urandom % 4 == 0) begin
                wordIdx = $urandom % `RAM_WORDS;
            end else begin
                wordIdx = $urandom % HotWords;
            end
            offset = ($urandom % (8 / nBytes)) * nBytes;
            ins.aluOut = 64'(wordIdx * 8 + offset);
        end else begin
            ins.aluOut = {$urandom, $urandom};
        end
        return ins;
    endfunction

    // Present one instruction, follow it to its result and check it.
    task automatic runOne(input memPkg::execData ins);
        logic        fl;
        logic        isMem;
        int          cycles;
        logic [63:0] expData;
        isMem = ins.valid && ins.ctl.memAccess;
        fl = pickFlush();
        @(posedge clk);
        dataE <= ins;
        flush <= fl;
        @(negedge clk);
        if (isMem) begin
            checkValue("memStall", 64'(memStall), 64'h1);
            checkValue("dataM.valid", 64'(dataM.valid), 64'h0);
            cycles = 0;
            while (memStall) begin
                fl = pickFlush();
                @(posedge clk);
                flush <= fl;
                @(negedge clk);
                cycles++;
                if (memStall) begin
                    checkValue("dataM.valid", 64'(dataM.valid), 64'h0);
                end
            end
            checkValue("latency", 64'(cycles), 64'(`RAM_LATENCY + 1));
        end else begin
            checkValue("memStall", 64'(memStall), 64'h0);
        end
        checkValue("dataM.valid", 64'(dataM.valid), 64'(ins.valid && !fl));
        checkValue("dataM.ctl", 64'(dataM.ctl), 64'(ins.ctl));
        checkValue("dataM.dst", 64'(dataM.dst), 64'(ins.dst));
        checkValue("dataM.instr", 64'(dataM.instr), 64'(ins.instr));
        checkValue("dataM.memAddr", dataM.memAddr, ins.aluOut);
        if (isMem && !isStoreOp(ins.ctl.op)) begin
            expData = expectLoad(ins.ctl.op, ins.aluOut);
        end else begin
            expData = ins.aluOut;
        end
        if (isMem || !ins.ctl.memAccess) begin
            checkValue("dataM.writeData", dataM.writeData, expData);
        end
        // A flushed store has still reached the RAM.
        if (isMem && isStoreOp(ins.ctl.op)) begin
            applyStore(ins);
        end
    endtask

    initial begin
        memPkg::execData ins;
        seedValue = $urandom(78787);
        for (int i = 0; i < `RAM_WORDS * 8; i++) begin
            refMem[i] = 8'h00;
        end
        reset = 1'b1;
        flush = 1'b0;
        dataE = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("memStall", 64'(memStall), 64'h0);
        checkValue("dataM.valid", 64'(dataM.valid), 64'h0);

        for (int n = 0; n < NumInstr; n++) begin
            ins = makeInstr();
            runOne(ins);
        end

        // Read back every busy word as a full doubleword.
        for (int w = 0; w < HotWords; w++) begin
            ins = '0;
            ins.valid = 1'b1;
            ins.ctl.op = memPkg::opLd;
            ins.ctl.memAccess = 1'b1;
            ins.aluOut = 64'(w * 8);
            ins.rd = {$urandom, $urandom};
            ins.dst = 5'($urandom);
            ins.instr = $urandom;
            runOne(ins);
        end

        @(posedge clk);
        dataE <= '0;
        flush <= 1'b0;
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Timeout: the run did not finish within %0d cycles.", TimeoutCycles);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired.");
    end

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`default_nettype none

// Free-running clock for the testbench.
module tbClock #(
    parameter int Period = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #(Period / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== memSubsystem.sv ====
`default_nettype none

module memSubsystem (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  memPkg::execData dataE,
    output logic            memStall,
    output memPkg::memData  dataM
);

    memPkg::dbusReq  dreq;
    memPkg::dbusResp dresp;

    memoryStage memoryStage_inst (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .dataE    (dataE),
        .dresp    (dresp),
        .dreq     (dreq),
        .memStall (memStall),
        .dataM    (dataM)
    );

    dataRam dataRam_inst (
        .clk   (clk),
        .reset (reset),
        .req   (dreq),
        .resp  (dresp)
    );

endmodule

`default_nettype wire

// ==== dataRam.sv ====
`default_nettype none

`include "memConfig_config.svh"

module dataRam (
    input  logic            clk,
    input  logic            reset,
    input  memPkg::dbusReq  req,
    output memPkg::dbusResp resp
);

    localparam int IdxW = $clog2(`RAM_WORDS);
    localparam int CntW = $clog2(`RAM_LATENCY + 1);

    memPkg::dword    mem [`RAM_WORDS];
    logic [IdxW-1:0] index;
    logic [CntW-1:0] count;
    logic            dataOk;

    // Word index from the doubleword address bits.
    assign index = req.addr[IdxW+2:3];

    // Answer in the RAM_LATENCY-th cycle of valid.
    assign dataOk = req.valid && (count == CntW'(`RAM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (dataOk) begin
            count <= '0;
        end else if (req.valid) begin
            count <= count + 1'b1;
        end
    end

    initial begin
        for (int w = 0; w < `RAM_WORDS; w++) begin
            mem[w] = '0;
        end
    end

    // Only the strobed byte lanes change.
    always_ff @(posedge clk) begin
        if (dataOk) begin
            for (int i = 0; i < 8; i++) begin
                if (req.strobe[i]) begin
                    mem[index].lanes[i] <= req.data[8*i +: 8];
                end
            end
        end
    end

    assign resp.dataOk = dataOk;
    assign resp.data   = mem[index].whole;

    // A new request is answered in its RAM_LATENCY-th cycle, still under valid.
    okAfterLatency: assert property (@(posedge clk) disable iff (reset)
        $rose(req.valid) |-> ##(`RAM_LATENCY - 1) (resp.dataOk && req.valid));

endmodule

`default_nettype wire

// ==== memoryStage.sv ====
`default_nettype none

`include "memConfig_config.svh"

module memoryStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  memPkg::execData dataE,
    input  memPkg::dbusResp dresp,
    output memPkg::dbusReq  dreq,
    output logic            memStall,
    output memPkg::memData  dataM
);

    memPkg::accessState state;
    memPkg::accessState stateNext;
    logic [`XLEN-1:0]   capWord;
    logic [`XLEN-1:0]   loadValue;
    logic               memInstr;
    logic               isLoad;

    assign memInstr = dataE.valid && dataE.ctl.memAccess;
    assign isLoad   = dataE.ctl.op inside {memPkg::opLd, memPkg::opLw, memPkg::opLwu,
                                           memPkg::opLh, memPkg::opLhu,
                                           memPkg::opLb, memPkg::opLbu};

    storeFormatter storeFormatter_inst (
        .op       (dataE.ctl.op),
        .addr     (dataE.aluOut),
        .storeSrc (dataE.rd),
        .size     (dreq.size),
        .strobe   (dreq.strobe),
        .laneData (dreq.data)
    );

    loadExtender loadExtender_inst (
        .op         (dataE.ctl.op),
        .byteOffset (dataE.aluOut[2:0]),
        .rawWord    (capWord),
        .loadValue  (loadValue)
    );

    assign dreq.valid = (state == memPkg::waiting);
    assign dreq.addr  = dataE.aluOut;

    assign memStall = (state == memPkg::waiting) || (state == memPkg::idle && memInstr);

    always_comb begin
        case (state)
            memPkg::idle:    stateNext = memInstr ? memPkg::waiting : memPkg::idle;
            memPkg::waiting: stateNext = dresp.dataOk ? memPkg::over : memPkg::waiting;
            default:         stateNext = memPkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= memPkg::idle;
            capWord <= '0;
        end else begin
            state <= stateNext;
            if (state == memPkg::waiting && dresp.dataOk) begin
                capWord <= dresp.data;
            end
        end
    end

    // Memory results leave in over, others pass straight through in idle.
    always_comb begin
        dataM.ctl     = dataE.ctl;
        dataM.dst     = dataE.dst;
        dataM.instr   = dataE.instr;
        dataM.memAddr = dataE.aluOut;
        if (dataE.ctl.memAccess) begin
            dataM.valid = dataE.valid && !flush && (state == memPkg::over);
        end else begin
            dataM.valid = dataE.valid && !flush && (state == memPkg::idle);
        end
        if (dataE.ctl.memAccess && isLoad) begin
            dataM.writeData = loadValue;
        end else begin
            dataM.writeData = dataE.aluOut;
        end
    end

    // Upstream must hold the instruction until the bus answers.
    reqStable: assert property (@(posedge clk) disable iff (reset)
        dreq.valid && !dresp.dataOk |=>
            $stable({dreq.addr, dreq.size, dreq.strobe, dreq.data}));

    strobeOnlyStore: assert property (@(posedge clk) disable iff (reset)
        dreq.valid && (dreq.strobe != 8'h00) |->
            dataE.ctl.op inside {memPkg::opSd, memPkg::opSw, memPkg::opSh, memPkg::opSb});

endmodule

`default_nettype wire

// ==== loadExtender.sv ====
`default_nettype none

module loadExtender (
    input  memPkg::memOp op,
    input  logic [2:0]   byteOffset,
    input  logic [63:0]  rawWord,
    output logic [63:0]  loadValue
);

    logic [5:0]  bitOffset;
    logic [63:0] shifted;

    assign bitOffset = {byteOffset, 3'b000};

    // Bring the addressed bytes down to lane zero.
    assign shifted = rawWord >> bitOffset;

    always_comb begin
        case (op)
            memPkg::opLw: begin
                loadValue = {{32{shifted[31]}}, shifted[31:0]};
            end
            memPkg::opLwu: begin
                loadValue = {32'b0, shifted[31:0]};
            end
            memPkg::opLh: begin
                loadValue = {{48{shifted[15]}}, shifted[15:0]};
            end
            memPkg::opLhu: begin
                loadValue = {48'b0, shifted[15:0]};
            end
            memPkg::opLb: begin
                loadValue = {{56{shifted[7]}}, shifted[7:0]};
            end
            memPkg::opLbu: begin
                loadValue = {56'b0, shifted[7:0]};
            end
            default: begin
                // Full doubleword, no extension needed.
                loadValue = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== storeFormatter.sv ====
`default_nettype none

module storeFormatter (
    input  memPkg::memOp   op,
    input  logic [63:0]    addr,
    input  logic [63:0]    storeSrc,
    output memPkg::memSize size,
    output logic [7:0]     strobe,
    output logic [63:0]    laneData
);

    logic [2:0] byteOffset;
    logic [5:0] bitOffset;
    logic [7:0] sizeMask;
    logic       isStore;

    assign byteOffset = addr[2:0];
    assign bitOffset  = {byteOffset, 3'b000};

    always_comb begin
        case (op)
            memPkg::opLd, memPkg::opSd: begin
                size = memPkg::size8;
            end
            memPkg::opLw, memPkg::opLwu, memPkg::opSw: begin
                size = memPkg::size4;
            end
            memPkg::opLh, memPkg::opLhu, memPkg::opSh: begin
                size = memPkg::size2;
            end
            default: begin
                size = memPkg::size1;
            end
        endcase
    end

    // All-ones mask as wide as the access.
    always_comb begin
        case (size)
            memPkg::size8: sizeMask = 8'hff;
            memPkg::size4: sizeMask = 8'h0f;
            memPkg::size2: sizeMask = 8'h03;
            default:       sizeMask = 8'h01;
        endcase
    end

    assign isStore  = op inside {memPkg::opSd, memPkg::opSw, memPkg::opSh, memPkg::opSb};
    assign strobe   = isStore ? (sizeMask << byteOffset) : 8'h00;
    assign laneData = storeSrc << bitOffset;

endmodule

`default_nettype wire

// ==== memPkg.sv ====
`default_nettype none

`include "memConfig_config.svh"

package memPkg;

    typedef enum logic [3:0] {
        opNone,
        opLd,
        opLw,
        opLwu,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSd,
        opSw,
        opSh,
        opSb
    } memOp;

    typedef enum logic [1:0] {
        size1,
        size2,
        size4,
        size8
    } memSize;

    typedef struct packed {
        memOp op;
        logic memAccess;
    } ctlFields;

    // Executed instruction as handed over by the execute stage.
    typedef struct packed {
        logic              valid;
        ctlFields          ctl;
        logic [`XLEN-1:0]  aluOut;
        logic [`XLEN-1:0]  rd;
        logic [4:0]        dst;
        logic [31:0]       instr;
    } execData;

    typedef struct packed {
        logic              valid;
        ctlFields          ctl;
        logic [4:0]        dst;
        logic [31:0]       instr;
        logic [`XLEN-1:0]  memAddr;
        logic [`XLEN-1:0]  writeData;
    } memData;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  addr;
        memSize            size;
        logic [7:0]        strobe;
        logic [`XLEN-1:0]  data;
    } dbusReq;

    typedef struct packed {
        logic              dataOk;
        logic [`XLEN-1:0]  data;
    } dbusResp;

    typedef enum logic [1:0] {
        idle,
        waiting,
        over
    } accessState;

    // One RAM word, seen as a whole or as byte lanes.
    typedef union packed {
        logic [`XLEN-1:0]  whole;
        logic [7:0][7:0]   lanes;
    } dword;

endpackage

`default_nettype wire

// ==== memConfig_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Data path width in bits.
`define XLEN 64

// Number of 64-bit words in the data RAM.
`define RAM_WORDS 256

// Cycles from the first cycle of request valid to dataOk, at least 1.
`define RAM_LATENCY 3

`endif
